// File: Bender.yml
package:
  name: tcp_tx_queue

sources:
  - files:
      - verilog/tcp_tx_pkg.sv
      - verilog/tx_data_buffer.sv
      - verilog/pkt_builder.sv
      - verilog/pkt_info_ram.sv
      - verilog/queue_scanner.sv
      - verilog/tcp_tx_queue_top.sv
  - target: test
    files:
      - verification/tcp_tx_queue_properties.sv
      - verification/tb_tcp_tx_queue.sv

// File: verification/tb_tcp_tx_queue.sv
/* testbench for the tcp transmit queue
   streams a table of bursts, models the transmitter and the remote ack,
   and checks every offered descriptor and payload byte against a reference */
module tb_tcp_tx_queue;
  import tcp_tx_pkg::*;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int MTU = 16, WAIT_TICKS = 4, MAX_TRIES = 2, INFO_DEPTH = 2, ROWS = 5;

  logic clk, rst, connected, in_v, cts, tx_busy, tx_done, pending, force_fin;
  logic [7:0] in_d, addr, data;
  seq_t       isn, rem_ack;
  tx_desc_t   desc;

  int burst_len [ROWS] = '{5, 16, 37, 64, 64};   // bytes per burst
  int gap_len   [ROWS] = '{40, 40, 150, 250, 0}; // idle cycles after it
  bit do_ack    [ROWS] = '{1, 1, 1, 1, 0};       // last row is never acked, fills every entry

  int seed = 32'hf1141146;
  int cycles, limit;
  bit started, ack_mode;

  // reference packets, built from the stream by the close rules
  logic [7:0] pay [256];
  seq_t   ref_seq [64];
  len_t   ref_len [64];
  chsum_t ref_sum [64];
  bit     ref_ack [64];
  bit     ack_sent [64]; // cumulative ack already given for this packet
  int     offers  [64];
  int     n_ref;
  int     n_ref_d;
  int     n_loaded;      // packets whose entry the DUT counts by now
  int     unacked;
  bit     collecting, bflag, close;
  seq_t   cur, bstart;
  int     blen, idle;
  seq_t   first_seq;     // seq of the very first offer
  bit     offered_any;

  tcp_tx_queue_top #(.MTU(MTU), .WAIT_TICKS(WAIT_TICKS), .RETRANSMIT_TICKS(8),
    .DATA_DEPTH(8), .INFO_DEPTH(INFO_DEPTH), .MAX_TRIES(MAX_TRIES)) dut (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR %s got %h expected %h", name, got, exp);
      $display("*** TEST FAILED ***");
      $fatal(1);
    end
  endtask

  // word sum straight from the byte array, odd tail padded with zero
  function automatic chsum_t payload_sum(input seq_t s, input int n);
    chsum_t acc;
    logic [7:0] lo;
    acc = '0;
    for (int i = 0; i < n; i += 2) begin
      lo  = (i + 1 < n) ? pay[8'(s + i + 1)] : 8'h00;
      acc = acc + {16'h0, pay[8'(s + i)], lo};
    end
    return acc;
  endfunction

  always @(negedge clk) begin // byte stream model, in_v here is what the DUT samples next
    if (started) begin
      n_loaded = n_ref_d; // entry counted two cycles after its close
      n_ref_d  = n_ref;
      unacked  = 0;
      for (int i = 0; i < n_loaded; i++) begin
        if (!ack_sent[i]) unacked++;
      end
      // unacked entries cannot be freed, so a full set blocks input
      if (unacked >= 2**INFO_DEPTH) check("cts", cts, 1'b0);
      close = collecting && (idle == WAIT_TICKS || blen == MTU);
      if (close) begin
        ref_seq[n_ref] = bstart;
        ref_len[n_ref] = len_t'(blen);
        ref_sum[n_ref] = payload_sum(bstart, blen);
        ref_ack[n_ref] = bflag;
        n_ref++;
      end
      if (!collecting || close) begin
        collecting = in_v;
        if (in_v) begin
          bstart = cur;
          blen   = 1;
          idle   = 0;
          bflag  = ack_mode;
        end
      end else if (in_v) begin
        blen++;
        idle = 0;
      end else idle++;
      if (in_v) begin
        pay[cur[7:0]] = in_d;
        cur++;
      end
    end
  end

  initial begin // transmitter and remote ack
    tx_desc_t d;
    int idx;
    forever begin
      @(negedge clk);
      if (pending) begin
        d   = desc;
        idx = -1;
        if (!offered_any) first_seq = d.seq;
        offered_any = 1'b1;
        for (int i = 0; i < n_ref; i++) if (ref_seq[i] == d.seq) idx = i;
        if (idx < 0) begin
          $display("offered seq %h matches no packet built from the stream", d.seq);
          $display("*** TEST FAILED ***");
          $fatal(1);
        end
        check("desc.len", d.len, ref_len[idx]);
        check("desc.chsum", d.chsum, ref_sum[idx]);
        offers[idx]++;
        for (int i = 0; i < d.len; i++) begin
          @(posedge clk);
          addr    <= 8'(d.seq + i);
          tx_busy <= 1'b1;
          @(posedge clk);
          @(negedge clk);
          check("data", data, pay[8'(d.seq + i)]);
        end
        @(posedge clk);
        tx_done <= 1'b1;
        tx_busy <= 1'b0;
        @(posedge clk);
        tx_done <= 1'b0;
        if (ref_ack[idx]) begin
          rem_ack <= d.seq + d.len; // cumulative ack of this packet
          ack_sent[idx] = 1'b1;
        end
        @(negedge clk);
        check("pending", pending, 1'b0);
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("timeout, the queue stopped making progress after %0d cycles", cycles);
      $display("*** TEST FAILED ***");
      $fatal(1);
    end
  end

  initial begin
    bit go;
    int sent, first_unacked;
    rst = 1'b1;
    connected = 1'b1;
    in_v = 1'b0;
    in_d = '0;
    addr = '0;
    tx_busy = 1'b0;
    tx_done = 1'b0;
    isn = $random(seed);
    rem_ack = isn;
    cur = isn;
    limit = 3000;
    for (int r = 0; r < ROWS; r++) limit += 20 * burst_len[r] + gap_len[r];
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    started = 1'b1;
    repeat (3) @(posedge clk);
    for (int r = 0; r < ROWS; r++) begin
      ack_mode = do_ack[r];
      sent = 0;
      while (sent < burst_len[r]) begin
        @(negedge clk);
        go = cts && !dut.load; // entry count cannot grow during the next cycle
        @(posedge clk);
        in_v <= go;
        in_d <= $random(seed);
        if (go) sent++;
      end
      @(posedge clk);
      in_v <= 1'b0;
      repeat (gap_len[r]) @(posedge clk);
    end
    wait (force_fin);
    @(negedge clk);
    @(negedge clk);
    check("first offered seq", first_seq, isn);
    first_unacked = -1;
    for (int i = 0; i < n_ref; i++) begin
      if (ref_ack[i]) check("offers of acked packet", offers[i], 1);
      else if (first_unacked < 0) first_unacked = i;
    end
    check("retransmits before force_fin", offers[first_unacked] >= MAX_TRIES + 1, 1'b1);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule : tb_tcp_tx_queue

// File: verification/tcp_tx_queue_properties.sv
/* port level assertions of the tcp transmit queue
   input only while cts, pending held until tx_done, force_fin sticky */
module tcp_tx_queue_properties (
  input logic clk,
  input logic rst,
  input logic cts,
  input logic in_v,
  input logic pending,
  input logic tx_done,
  input logic force_fin
);
  timeunit 1ns;
  timeprecision 1ps;

  in_v_needs_cts: assert property (@(posedge clk) disable iff (rst) in_v |-> cts)
    else $error("in_v high while cts low");

  // offer stays up until the transmitter ends the send
  pending_held: assert property (@(posedge clk) disable iff (rst)
    pending && !tx_done |=> pending)
    else $error("pending dropped before tx_done");

  // the queue reset follows rst by one cycle
  force_fin_sticky: assert property (@(posedge clk)
    $fell(force_fin) |-> $past(rst) || $past(rst, 2))
    else $error("force_fin fell without reset");

endmodule : tcp_tx_queue_properties

bind tcp_tx_queue_top tcp_tx_queue_properties props (
  .clk, .rst, .cts, .in_v, .pending, .tx_done, .force_fin
);

// File: verilog.f
verilog/tcp_tx_pkg.sv
verilog/tx_data_buffer.sv
verilog/pkt_builder.sv
verilog/pkt_info_ram.sv
verilog/queue_scanner.sv
verilog/tcp_tx_queue_top.sv
verification/tcp_tx_queue_properties.sv
verification/tb_tcp_tx_queue.sv

// File: verilog/pkt_builder.sv
/* packet builder
   cuts the incoming byte stream into packets on idle timeout, MTU or buffer
   full, sums big-endian 16-bit words and hands each closed packet to the
   info RAM one cycle after the close */
module pkt_builder import tcp_tx_pkg::*; #(
  parameter int MTU              = 16,
  parameter int WAIT_TICKS       = 4,
  parameter int RETRANSMIT_TICKS = 8,
  parameter int INFO_DEPTH       = 2
) (
  input  logic                  clk,
  input  logic                  rst,
  input  seq_t                  isn,
  input  logic                  in_v,
  input  logic [7:0]            in_d,
  input  logic                  full,
  output logic                  load,
  output logic [INFO_DEPTH-1:0] new_addr,
  output logic [INFO_DEPTH:0]   new_ptr,
  output pkt_info_t             new_pkt
);

  localparam int IDLE_W = $clog2(WAIT_TICKS + 1);

  typedef enum logic {
    idle_s,
    collect_s
  } bld_state_t;

  bld_state_t        state;
  logic [IDLE_W-1:0] idle_ctr;  // idle cycles since the last byte
  seq_t              cur_seq;   // seq of the next incoming byte
  seq_t              start_seq; // seq of the packet's first byte
  len_t              len;
  chsum_t            sum;
  logic [7:0]        hi_byte;   // upper half of the word being formed
  logic              close;
  chsum_t            sum_final;

  assign close = (state == collect_s) &&
                 (idle_ctr == IDLE_W'(WAIT_TICKS) || len == len_t'(MTU) || full);
  assign sum_final = len[0] ? sum + chsum_t'({hi_byte, 8'h00}) : sum; // odd tail padded low
  assign new_addr  = new_ptr[INFO_DEPTH-1:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= idle_s;
      cur_seq  <= isn;
      idle_ctr <= '0;
      len      <= '0;
      load     <= 1'b0;
      new_ptr  <= '0;
    end else begin
      load <= close;                             // write entry the cycle after close
      if (load) new_ptr <= new_ptr + 1'b1;
      if (in_v) cur_seq <= cur_seq + 1'b1;
      if (state == idle_s || close) begin
        // a byte arriving on the close cycle opens the next packet
        if (in_v) begin
          state     <= collect_s;
          start_seq <= cur_seq;
          len       <= len_t'(1);
          hi_byte   <= in_d;
          sum       <= '0;
          idle_ctr  <= '0;
        end else begin
          state <= idle_s;
        end
      end else if (in_v) begin
        len      <= len + 1'b1;
        idle_ctr <= '0;                           // timeout restarts on every byte
        if (len[0]) sum <= sum + chsum_t'({hi_byte, in_d});
        else hi_byte <= in_d;
      end else begin
        idle_ctr <= idle_ctr + 1'b1;
      end
    end
  end

  // entry captured at close, valid while load is high
  always_ff @(posedge clk) begin
    if (close) begin
      new_pkt.present   <= 1'b1;
      new_pkt.seq       <= start_seq;
      new_pkt.exp_ack   <= start_seq + seq_t'(len);
      new_pkt.length    <= len;
      new_pkt.chsum     <= sum_final;
      new_pkt.rtx_timer <= rtx_timer_t'(RETRANSMIT_TICKS); // first send on first visit
      new_pkt.rtx_tries <= '0;
    end
  end

endmodule : pkt_builder

// File: verilog/pkt_info_ram.sv
/* packet info RAM
   add port takes new entries from the builder, update port is read and
   written back by the scanner. a write returns the new value on its port */
module pkt_info_ram import tcp_tx_pkg::*; #(
  parameter int INFO_DEPTH = 2
) (
  input  logic                  clk,
  input  logic                  load,
  input  logic [INFO_DEPTH-1:0] new_addr,
  input  pkt_info_t             new_pkt,
  input  logic                  upd,
  input  logic [INFO_DEPTH-1:0] upd_addr,
  input  pkt_info_t             upd_pkt,
  output pkt_info_t             upd_pkt_q
);

  pkt_info_t mem [2**INFO_DEPTH];

  initial begin
    for (int i = 0; i < 2**INFO_DEPTH; i++) mem[i] = '0; // all entries start empty
  end

  always @(posedge clk) begin
    if (load) mem[new_addr] <= new_pkt; // add port, write only
  end

  always @(posedge clk) begin
    if (upd) begin
      mem[upd_addr] <= upd_pkt;
      upd_pkt_q     <= upd_pkt; // write-first on this port
    end else begin
      upd_pkt_q <= mem[upd_addr];
    end
  end

endmodule : pkt_info_ram

// File: verilog/queue_scanner.sv
/* queue scanner
   walks the info entries in a loop, frees acked packets in order, offers
   first sends and retransmits to the transmitter and raises force_fin once
   a packet has used up its tries */
module queue_scanner import tcp_tx_pkg::*; #(
  parameter int RETRANSMIT_TICKS = 8,
  parameter int INFO_DEPTH       = 2,
  parameter int MAX_TRIES        = 2
) (
  input  logic                  clk,
  input  logic                  rst,
  input  seq_t                  rem_ack,
  input  logic                  tx_busy,
  input  logic                  tx_done,
  input  logic                  load,
  input  pkt_info_t             upd_pkt_q,
  output logic                  upd,
  output logic [INFO_DEPTH-1:0] upd_addr,
  output pkt_info_t             upd_pkt,
  output logic [INFO_DEPTH:0]   free_ptr,
  output seq_t                  free_ack,
  output logic                  pending,
  output tx_desc_t              desc,
  output logic                  force_fin
);

  scan_state_t state;
  seq_t        ack_diff;
  logic        acked;
  logic        oldest;
  logic        rtx_due;

  assign ack_diff = upd_pkt_q.exp_ack - rem_ack;
  assign acked    = ack_diff[31] || ack_diff == '0; // exp_ack at or behind rem_ack
  // free strictly in queue order so free_ptr always names the oldest slot
  assign oldest   = (upd_addr == free_ptr[INFO_DEPTH-1:0]);
  assign rtx_due  = (upd_pkt_q.rtx_timer == rtx_timer_t'(RETRANSMIT_TICKS));

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= scan_s;
      upd       <= 1'b0;
      upd_addr  <= '0;
      free_ptr  <= '0;
      free_ack  <= rem_ack;
      pending   <= 1'b0;
      force_fin <= 1'b0;
    end else begin
      case (state)
        scan_s: begin
          upd   <= 1'b0;
          state <= read_s; // RAM output follows upd_addr next cycle
        end
        read_s: begin
          if (upd_pkt_q.present) begin
            state <= check_s;
          end else begin
            upd_addr <= upd_addr + 1'b1; // empty slot
            state    <= scan_s;
          end
        end
        check_s: begin
          if (!tx_busy && !load) begin
            if (acked) begin
              if (oldest) begin
                upd      <= 1'b1;
                upd_pkt  <= '0;               // entry released
                free_ptr <= free_ptr + 1'b1;
                free_ack <= upd_pkt_q.exp_ack; // whole packet acked, data may go
              end
              state <= next_s;
            end else if (rtx_due) begin
              upd               <= 1'b1;
              upd_pkt           <= upd_pkt_q;
              upd_pkt.rtx_timer <= '0;
              upd_pkt.rtx_tries <= upd_pkt_q.rtx_tries +
                                   rtx_tries_t'(upd_pkt_q.rtx_tries != '1); // saturating
              pending    <= 1'b1;
              desc.seq   <= upd_pkt_q.seq;
              desc.len   <= upd_pkt_q.length;
              desc.chsum <= upd_pkt_q.chsum;
              if (upd_pkt_q.rtx_tries == rtx_tries_t'(MAX_TRIES)) force_fin <= 1'b1;
              state <= retrans_s;
            end else begin
              upd               <= 1'b1;
              upd_pkt           <= upd_pkt_q;
              upd_pkt.rtx_timer <= upd_pkt_q.rtx_timer + 1'b1; // age by one visit
              state             <= next_s;
            end
          end
        end
        next_s: begin
          upd      <= 1'b0;                  // write lands this cycle at old address
          upd_addr <= upd_addr + 1'b1;
          state    <= scan_s;
        end
        retrans_s: begin
          upd <= 1'b0;
          if (tx_done) begin
            pending  <= 1'b0;
            upd_addr <= upd_addr + 1'b1;
            state    <= scan_s;
          end
        end
        default: begin
          upd     <= 1'b0;
          pending <= 1'b0;
          state   <= scan_s;
        end
      endcase
    end
  end

endmodule : queue_scanner

// File: verilog/tcp_tx_pkg.sv
/* tcp transmit queue types
   widths of sequence, length and sum fields, the packet info entry kept per
   queued packet, the descriptor offered to the transmitter and scanner states */
package tcp_tx_pkg;

  typedef logic [31:0] seq_t;   // tcp sequence number
  typedef logic [15:0] len_t;   // payload length in bytes
  typedef logic [31:0] chsum_t; // unfolded 16-bit word sum of the payload

  localparam int RTX_TIMER_W = 20; // RETRANSMIT_TICKS must fit here

  typedef logic [RTX_TIMER_W-1:0] rtx_timer_t;
  typedef logic [1:0]             rtx_tries_t;

  // one queued packet, still unacked while present is set
  typedef struct packed {
    logic       present;
    seq_t       seq;       // first byte
    seq_t       exp_ack;   // seq just past the last byte
    len_t       length;
    chsum_t     chsum;
    rtx_timer_t rtx_timer; // scan visits since last send
    rtx_tries_t rtx_tries; // sends so far
  } pkt_info_t;

  // what the transmitter needs to build and send one packet
  typedef struct packed {
    seq_t   seq;
    len_t   len;
    chsum_t chsum;
  } tx_desc_t;

  // scanner walk over the info entries
  typedef enum logic [2:0] {
    scan_s,    // address presented, wait for read data
    read_s,    // entry visible, skip if empty
    check_s,   // decide free / send / age
    next_s,    // write back, step to next entry
    retrans_s  // offer pending, wait for tx_done
  } scan_state_t;

endpackage : tcp_tx_pkg

// File: verilog/tcp_tx_queue_top.sv
/* tcp transmit queue
   payload bytes go into the data buffer while the builder records packets
   in the info RAM. the scanner offers them to the transmitter until acked */
module tcp_tx_queue_top import tcp_tx_pkg::*; #(
  parameter int MTU              = 16,
  parameter int WAIT_TICKS       = 4,
  parameter int RETRANSMIT_TICKS = 8,
  parameter int DATA_DEPTH       = 8,
  parameter int INFO_DEPTH       = 2,
  parameter int MAX_TRIES        = 2
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  connected,
  input  seq_t                  isn,
  input  logic [7:0]            in_d,
  input  logic                  in_v,
  output logic                  cts,
  input  seq_t                  rem_ack,
  input  logic                  tx_busy,
  input  logic                  tx_done,
  input  logic [DATA_DEPTH-1:0] addr,
  output logic [7:0]            data,
  output logic                  pending,
  output tx_desc_t              desc,
  output logic                  force_fin
);

  logic                  q_rst;       // rst or a connected edge
  logic                  connected_q;
  logic                  full;
  logic                  load;
  logic                  upd;
  logic [INFO_DEPTH-1:0] new_addr;
  logic [INFO_DEPTH-1:0] upd_addr;
  logic [INFO_DEPTH:0]   new_ptr;
  logic [INFO_DEPTH:0]   free_ptr;
  logic [INFO_DEPTH:0]   used_entries;
  pkt_info_t             new_pkt;
  pkt_info_t             upd_pkt;
  pkt_info_t             upd_pkt_q;
  seq_t                  free_ack;

  always_ff @(posedge clk) begin
    connected_q <= connected;
    q_rst       <= rst || (connected != connected_q); // any change restarts the queue
  end

  assign used_entries = new_ptr - free_ptr;
  // msb set means every entry is taken
  assign cts = connected && !full && !used_entries[INFO_DEPTH];

  tx_data_buffer #(.DATA_DEPTH(DATA_DEPTH)) data_buf (
    .clk, .rst(q_rst), .isn, .in_v, .in_d, .free_ack, .addr, .data, .space(), .full
  );

  pkt_builder #(
    .MTU(MTU), .WAIT_TICKS(WAIT_TICKS), .RETRANSMIT_TICKS(RETRANSMIT_TICKS),
    .INFO_DEPTH(INFO_DEPTH)
  ) builder (
    .clk, .rst(q_rst), .isn, .in_v, .in_d, .full, .load, .new_addr, .new_ptr, .new_pkt
  );

  pkt_info_ram #(.INFO_DEPTH(INFO_DEPTH)) info_ram (
    .clk, .load, .new_addr, .new_pkt, .upd, .upd_addr, .upd_pkt, .upd_pkt_q
  );

  queue_scanner #(
    .RETRANSMIT_TICKS(RETRANSMIT_TICKS), .INFO_DEPTH(INFO_DEPTH), .MAX_TRIES(MAX_TRIES)
  ) scanner (
    .clk, .rst(q_rst), .rem_ack, .tx_busy, .tx_done, .load, .upd_pkt_q, .upd, .upd_addr,
    .upd_pkt, .free_ptr, .free_ack, .pending, .desc, .force_fin
  );

endmodule : tcp_tx_queue_top

// File: verilog/tx_data_buffer.sv
/* raw payload buffer of the transmit queue
   bytes are written at the low bits of their sequence number, the transmitter
   reads them back by address. occupancy runs from the last freed ack to the
   write sequence */
module tx_data_buffer import tcp_tx_pkg::*; #(
  parameter int DATA_DEPTH = 8
) (
  input  logic                  clk,
  input  logic                  rst,
  input  seq_t                  isn,
  input  logic                  in_v,
  input  logic [7:0]            in_d,
  input  seq_t                  free_ack,
  input  logic [DATA_DEPTH-1:0] addr,
  output logic [7:0]            data,
  output logic [DATA_DEPTH-1:0] space,
  output logic                  full
);

  logic [7:0] mem [2**DATA_DEPTH];

  seq_t wr_seq;  // seq of the next byte written
  seq_t ack_seq; // everything before this is released
  seq_t used;    // unacked bytes held
  seq_t adv;     // how far free_ack is ahead of ack_seq

  assign used  = wr_seq - ack_seq;
  assign adv   = free_ack - ack_seq;
  // one slot is kept back so wr_seq never laps the oldest byte
  assign space = (|used[31:DATA_DEPTH]) ? '0 : ~used[DATA_DEPTH-1:0];
  assign full  = (space == '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_seq  <= isn;
      ack_seq <= isn;
    end else begin
      if (in_v) wr_seq <= wr_seq + 1'b1;
      if (adv != '0 && adv <= used) ack_seq <= free_ack; // only move forward into written data
    end
  end

  always_ff @(posedge clk) begin
    if (in_v) mem[wr_seq[DATA_DEPTH-1:0]] <= in_d;
  end

  always_ff @(posedge clk) data <= mem[addr]; // one cycle read

endmodule : tx_data_buffer
